/* include/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data path and address width
`define LSU_DATA_W 32

// register file index width
`define LSU_REG_ADDR_W 5

// operations allowed in flight between issue and completion
`define LSU_QUEUE_DEPTH 4

`define LSU_OP_W 4

`endif

/* src/lsu_op_pkg.sv */
`include "lsu_defs.svh"

package lsu_op_pkg;

   typedef enum logic [`LSU_OP_W-1:0] {
      op_ld_b,
      op_ld_h,
      op_ld_w,
      op_ld_bu,
      op_ld_hu,
      op_st_b,
      op_st_h,
      op_st_w
   } lsu_op_e;

   typedef enum logic [1:0] {
      size_byte,
      size_half,
      size_word
   } lsu_size_e;

   typedef struct packed {
      logic      is_store;
      logic      is_unsigned;
      lsu_size_e size;
   } lsu_decoded_t;

   function automatic lsu_decoded_t lsu_decode(lsu_op_e op);
      lsu_decoded_t d;
      d.is_store    = op inside {op_st_b, op_st_h, op_st_w};
      d.is_unsigned = op inside {op_ld_bu, op_ld_hu};
      case (op)
         op_ld_b, op_ld_bu, op_st_b: d.size = size_byte;
         op_ld_h, op_ld_hu, op_st_h: d.size = size_half;
         default:                    d.size = size_word;
      endcase
      return d;
   endfunction

endpackage

/* src/lsu_mem_pkg.sv */
`include "lsu_defs.svh"

package lsu_mem_pkg;

   import lsu_op_pkg::*;

   typedef logic [`LSU_DATA_W-1:0]   lsu_addr_t;
   typedef logic [`LSU_DATA_W-1:0]   lsu_data_t;
   typedef logic [`LSU_DATA_W/8-1:0] lsu_strb_t;
   typedef logic [`LSU_REG_ADDR_W-1:0] lsu_reg_t;

   // holds 0 .. LSU_QUEUE_DEPTH
   typedef logic [$clog2(`LSU_QUEUE_DEPTH+1)-1:0] lsu_credit_t;

   // bookkeeping kept for each accepted operation until it completes
   typedef struct packed {
      logic [1:0] lane;
      lsu_size_e  size;
      logic       is_unsigned;
      logic       is_store;
      logic       ale;
      lsu_reg_t   rd;
      logic       wen;
   } lsu_pending_t;

   typedef struct packed {
      lsu_data_t data;
      lsu_reg_t  rd;
      logic      wen;
   } lsu_result_t;

   // one request from the execute stage
   typedef struct packed {
      lsu_op_e   op;
      lsu_data_t base;
      lsu_data_t offset;
      lsu_data_t wdata;
      lsu_reg_t  rd;
      logic      wen;
   } lsu_exec_req_t;

endpackage

/* src/lsu_issue.sv */
`include "lsu_defs.svh"

module lsu_issue
   import lsu_op_pkg::*, lsu_mem_pkg::*;
(
   input  logic          clk,
   input  logic          rst,

   input  logic          valid_e,
   input  lsu_exec_req_t exec_req,

   output logic          data_req,
   output lsu_addr_t     data_addr,
   output logic          data_wr,
   output lsu_strb_t     data_wstrb,
   output lsu_data_t     data_wdata,
   input  logic          data_addr_ok,

   output logic          lsu_ecl_ale_e,
   output logic          lsu_addr_finish,

   output logic          push,
   output lsu_pending_t  push_entry,
   input  logic          credit_return
);

   lsu_decoded_t dec;
   lsu_addr_t    addr;
   logic [1:0]   lane;
   logic         misaligned;
   logic         has_credit;
   lsu_strb_t    strb;
   lsu_credit_t  credits;

   assign dec  = lsu_decode(exec_req.op);
   assign addr = exec_req.base + exec_req.offset;
   assign lane = addr[1:0];

   always_comb begin
      case (dec.size)
         size_half: misaligned = lane[0];
         size_word: misaligned = (lane != 2'b00);
         default:   misaligned = 1'b0;
      endcase
   end

   assign has_credit    = (credits != '0);
   assign lsu_ecl_ale_e = valid_e & misaligned;

   // misaligned accesses stay off the bus
   assign data_req = valid_e & has_credit & ~misaligned;

   // a misaligned access completes its address phase without the bus
   assign lsu_addr_finish = (data_req & data_addr_ok) | (lsu_ecl_ale_e & has_credit);
   assign push            = lsu_addr_finish;

   assign data_addr = addr;
   assign data_wr   = dec.is_store;

   always_comb begin
      case (dec.size)
         size_byte: begin
            strb       = 4'b0001 << lane;
            data_wdata = {4{exec_req.wdata[7:0]}};
         end
         size_half: begin
            strb       = 4'b0011 << lane;
            data_wdata = {2{exec_req.wdata[15:0]}};
         end
         default: begin
            strb       = 4'b1111;
            data_wdata = exec_req.wdata;
         end
      endcase
   end

   // loads write no lanes
   assign data_wstrb = dec.is_store ? strb : '0;

   assign push_entry = '{
      lane:        lane,
      size:        dec.size,
      is_unsigned: dec.is_unsigned,
      is_store:    dec.is_store,
      ale:         misaligned,
      rd:          exec_req.rd,
      wen:         exec_req.wen
   };

   // one credit per free slot in the pending queue
   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= lsu_credit_t'(`LSU_QUEUE_DEPTH);
      end else begin
         case ({push, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

/* src/lsu_pending_queue.sv */
`include "lsu_defs.svh"

module lsu_pending_queue
   import lsu_mem_pkg::*;
#(
   parameter int DEPTH = `LSU_QUEUE_DEPTH
) (
   input  logic         clk,
   input  logic         rst,

   input  logic         push,
   input  lsu_pending_t push_entry,

   output logic         head_valid,
   output lsu_pending_t head,
   input  logic         pop,

   output logic         credit_return
);

   localparam int PTR_W = $clog2(DEPTH);

   lsu_pending_t     entries [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_pop;

   assign head_valid = (count != '0);
   assign head       = entries[rd_ptr];
   assign do_pop     = pop & head_valid;

   // the issue stage never pushes without a credit
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= push_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         credit_return <= do_pop;
      end
   end

endmodule

/* src/lsu_result_align.sv */
`include "lsu_defs.svh"

module lsu_result_align
   import lsu_op_pkg::*, lsu_mem_pkg::*;
(
   input  logic         clk,
   input  logic         rst,

   input  logic         head_valid,
   input  lsu_pending_t head,
   output logic         pop,

   input  logic         data_data_ok,
   input  lsu_data_t    data_rdata,

   output logic         lsu_finish_m,
   output lsu_result_t  result
);

   localparam int HOLD_DEPTH = `LSU_QUEUE_DEPTH;
   localparam int HOLD_PTR_W = $clog2(HOLD_DEPTH);

   lsu_data_t             hold_mem [HOLD_DEPTH];
   logic [HOLD_PTR_W-1:0] hold_wr;
   logic [HOLD_PTR_W-1:0] hold_rd;
   logic [HOLD_PTR_W:0]   hold_cnt;
   logic                  hold_any;
   logic                  hold_push;
   logic                  hold_pop;
   logic                  mem_done;
   lsu_data_t             load_word;
   lsu_data_t             shifted;
   lsu_data_t             ext;

   // read data that arrives while an exception entry is at the head
   // belongs to a later entry and waits here
   assign hold_any  = (hold_cnt != '0);
   assign load_word = hold_any ? hold_mem[hold_rd] : data_rdata;

   assign mem_done  = head_valid & ~head.ale & (hold_any | data_data_ok);
   assign pop       = (head_valid & head.ale) | mem_done;
   assign hold_pop  = mem_done & hold_any;
   assign hold_push = data_data_ok & ~(mem_done & ~hold_any);

   always_ff @(posedge clk) begin
      if (hold_push) begin
         hold_mem[hold_wr] <= data_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         hold_wr  <= '0;
         hold_rd  <= '0;
         hold_cnt <= '0;
      end else begin
         if (hold_push) begin
            hold_wr <= hold_wr + 1'b1;
         end
         if (hold_pop) begin
            hold_rd <= hold_rd + 1'b1;
         end
         case ({hold_push, hold_pop})
            2'b10:   hold_cnt <= hold_cnt + 1'b1;
            2'b01:   hold_cnt <= hold_cnt - 1'b1;
            default: hold_cnt <= hold_cnt;
         endcase
      end
   end

   // bring the addressed lane down to bit 0
   assign shifted = load_word >> {head.lane, 3'b000};

   always_comb begin
      case (head.size)
         size_byte: begin
            if (head.is_unsigned) begin
               ext = {24'h0, shifted[7:0]};
            end else begin
               ext = {{24{shifted[7]}}, shifted[7:0]};
            end
         end
         size_half: begin
            if (head.is_unsigned) begin
               ext = {16'h0, shifted[15:0]};
            end else begin
               ext = {{16{shifted[15]}}, shifted[15:0]};
            end
         end
         default: ext = load_word;
      endcase
      if (head.is_store || head.ale) begin
         ext = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_finish_m <= 1'b0;
      end else begin
         lsu_finish_m <= pop;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         result <= '{data: ext, rd: head.rd, wen: head.wen};
      end
   end

endmodule

/* src/lsu_top.sv */
module lsu_top
   import lsu_mem_pkg::*;
(
   input  logic          clk,
   input  logic          rst,

   // execute stage
   input  logic          valid_e,
   input  lsu_exec_req_t exec_req,
   output logic          lsu_addr_finish,
   output logic          lsu_ecl_ale_e,

   // data bus
   output logic          data_req,
   output lsu_addr_t     data_addr,
   output logic          data_wr,
   output lsu_strb_t     data_wstrb,
   output lsu_data_t     data_wdata,
   input  logic          data_addr_ok,
   input  logic          data_data_ok,
   input  lsu_data_t     data_rdata,

   // memory stage writeback
   output logic          lsu_finish_m,
   output lsu_data_t     read_result_m,
   output lsu_reg_t      lsu_ecl_rd_m,
   output logic          lsu_ecl_wen_m
);

   logic         push;
   lsu_pending_t push_entry;
   logic         credit_return;
   logic         head_valid;
   lsu_pending_t head;
   logic         pop;
   lsu_result_t  result;

   lsu_issue u_issue (
      .clk             (clk),
      .rst             (rst),
      .valid_e         (valid_e),
      .exec_req        (exec_req),
      .data_req        (data_req),
      .data_addr       (data_addr),
      .data_wr         (data_wr),
      .data_wstrb      (data_wstrb),
      .data_wdata      (data_wdata),
      .data_addr_ok    (data_addr_ok),
      .lsu_ecl_ale_e   (lsu_ecl_ale_e),
      .lsu_addr_finish (lsu_addr_finish),
      .push            (push),
      .push_entry      (push_entry),
      .credit_return   (credit_return)
   );

   lsu_pending_queue u_queue (
      .clk           (clk),
      .rst           (rst),
      .push          (push),
      .push_entry    (push_entry),
      .head_valid    (head_valid),
      .head          (head),
      .pop           (pop),
      .credit_return (credit_return)
   );

   lsu_result_align u_align (
      .clk          (clk),
      .rst          (rst),
      .head_valid   (head_valid),
      .head         (head),
      .pop          (pop),
      .data_data_ok (data_data_ok),
      .data_rdata   (data_rdata),
      .lsu_finish_m (lsu_finish_m),
      .result       (result)
   );

   assign read_result_m = result.data;
   assign lsu_ecl_rd_m  = result.rd;
   assign lsu_ecl_wen_m = result.wen;

endmodule

/* sim/lsu_props.sv */
`include "lsu_defs.svh"

module lsu_props (
   input logic clk,
   input logic rst,
   input logic data_req,
   input logic lsu_ecl_ale_e,
   input logic lsu_addr_finish,
   input logic lsu_finish_m
);

   int outstanding;

   // accepted operations whose completion has not been seen yet
   always_ff @(posedge clk) begin
      if (rst) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + int'(lsu_addr_finish) - int'(lsu_finish_m);
      end
   end

   ale_keeps_bus_idle: assert property (@(posedge clk) disable iff (rst)
      lsu_ecl_ale_e |-> !data_req)
      else $error("data_req raised for a misaligned access");

   depth_limit: assert property (@(posedge clk) disable iff (rst)
      outstanding <= `LSU_QUEUE_DEPTH)
      else $error("outstanding operations exceed the queue depth");

   quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !lsu_finish_m)
      else $error("lsu_finish_m high in the cycle after reset");

endmodule

bind lsu_top lsu_props u_props (
   .clk             (clk),
   .rst             (rst),
   .data_req        (data_req),
   .lsu_ecl_ale_e   (lsu_ecl_ale_e),
   .lsu_addr_finish (lsu_addr_finish),
   .lsu_finish_m    (lsu_finish_m)
);

/* sim/lsu_tb.sv */
`include "lsu_defs.svh"

module lsu_tb
   import lsu_op_pkg::*, lsu_mem_pkg::*;
();

   localparam int DEPTH = `LSU_QUEUE_DEPTH;

   logic          clk;
   logic          rst;
   logic          valid_e;
   lsu_exec_req_t exec_req;
   logic          lsu_addr_finish;
   logic          lsu_ecl_ale_e;
   logic          data_req;
   lsu_addr_t     data_addr;
   logic          data_wr;
   lsu_strb_t     data_wstrb;
   lsu_data_t     data_wdata;
   logic          data_addr_ok;
   logic          data_data_ok;
   lsu_data_t     data_rdata;
   logic          lsu_finish_m;
   lsu_data_t     read_result_m;
   lsu_reg_t      lsu_ecl_rd_m;
   logic          lsu_ecl_wen_m;

   lsu_data_t   mem [64];
   lsu_data_t   shadow [64];
   lsu_data_t   resp_q [$];
   lsu_result_t sb [$];
   int          grant_pct;
   int          resp_pct;
   int          checks;
   int          errors;
   int          test_errors;
   string       test_name;

   lsu_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic lsu_data_t fill_word(input int i);
      return {8'(i), ~8'(i), 8'(i * 37 + 5), 8'(i) ^ 8'hc3};
   endfunction

   function automatic logic is_misaligned(input lsu_op_e op, input lsu_addr_t addr);
      case (op)
         op_ld_h, op_ld_hu, op_st_h: return addr[0];
         op_ld_w, op_st_w:           return addr[1:0] != 2'b00;
         default:                    return 1'b0;
      endcase
   endfunction

   // expected writeback for one operation given the memory word before the access
   function automatic lsu_result_t expected_result(input lsu_op_e op, input lsu_addr_t addr,
                                                   input lsu_data_t word, input lsu_reg_t rd,
                                                   input logic wen);
      logic [7:0]  b;
      logic [15:0] h;
      lsu_data_t   d;
      b = word[8*addr[1:0] +: 8];
      h = word[16*addr[1] +: 16];
      case (op)
         op_ld_b:  d = {{24{b[7]}}, b};
         op_ld_bu: d = {24'h0, b};
         op_ld_h:  d = {{16{h[15]}}, h};
         op_ld_hu: d = {16'h0, h};
         op_ld_w:  d = word;
         default:  d = '0;
      endcase
      if (is_misaligned(op, addr)) begin
         d = '0;
      end
      return '{data: d, rd: rd, wen: wen};
   endfunction

   task automatic write_shadow(input lsu_op_e op, input lsu_addr_t addr, input lsu_data_t wdata);
      case (op)
         op_st_b: shadow[addr[7:2]][8*addr[1:0] +: 8] = wdata[7:0];
         op_st_h: shadow[addr[7:2]][16*addr[1] +: 16] = wdata[15:0];
         op_st_w: shadow[addr[7:2]] = wdata;
         default: ;
      endcase
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $finish;
   endtask

   // memory model with random grant and in-order answers
   // stores land in the array at acceptance
   initial begin
      int idx;
      data_addr_ok = 1'b0;
      data_data_ok = 1'b0;
      data_rdata   = '0;
      for (int i = 0; i < 64; i++) begin
         mem[i] = fill_word(i);
      end
      forever begin
         @(negedge clk);
         data_data_ok = 1'b0;
         if (resp_q.size() > 0 && $urandom_range(99, 0) < resp_pct) begin
            data_data_ok = 1'b1;
            data_rdata   = resp_q.pop_front();
         end
         data_addr_ok = ($urandom_range(99, 0) < grant_pct);
         #1;
         if (data_req === 1'b1 && data_addr_ok) begin
            idx = int'(data_addr[7:2]);
            resp_q.push_back(mem[idx]);
            for (int b = 0; b < 4; b++) begin
               if (data_wr && data_wstrb[b]) begin
                  mem[idx][8*b +: 8] = data_wdata[8*b +: 8];
               end
            end
         end
      end
   end

   // compares each completion with the oldest logged operation
   initial begin
      lsu_result_t exp;
      lsu_result_t got;
      forever begin
         @(negedge clk);
         if (lsu_finish_m === 1'b1) begin
            got = '{data: read_result_m, rd: lsu_ecl_rd_m, wen: lsu_ecl_wen_m};
            if (sb.size() == 0) begin
               errors++;
               $display("%s: completion seen with no operation outstanding", test_name);
            end else begin
               exp = sb.pop_front();
               checks++;
               if (got !== exp) begin
                  errors++;
                  $display("Mismatch in %s: expected %h rd %0d wen %b, actual %h rd %0d wen %b",
                           test_name, exp.data, exp.rd, exp.wen, got.data, got.rd, got.wen);
               end
            end
         end
         if (sb.size() > DEPTH) begin
            errors++;
            $display("%s: more than %0d operations outstanding", test_name, DEPTH);
         end
      end
   end

   task automatic issue_op(input lsu_op_e op, input lsu_addr_t addr, input lsu_data_t wdata,
                           input lsu_reg_t rd, input logic wen);
      lsu_addr_t base;
      logic      exp_ale;
      logic      exp_wr;
      int        waited;
      base    = lsu_addr_t'($urandom_range(255, 0));
      exp_ale = is_misaligned(op, addr);
      exp_wr  = (op == op_st_b || op == op_st_h || op == op_st_w);
      waited  = 0;
      @(negedge clk);
      valid_e  = 1'b1;
      exec_req = '{op: op, base: base, offset: addr - base, wdata: wdata, rd: rd, wen: wen};
      #1;
      while (lsu_addr_finish !== 1'b1 && waited < 500) begin
         waited++;
         @(negedge clk);
         #1;
      end
      if (lsu_addr_finish !== 1'b1) begin
         abort_run($sformatf("%s: operation at %h was never accepted", test_name, addr));
      end else begin
         if (lsu_ecl_ale_e !== exp_ale) begin
            errors++;
            $display("Mismatch in %s: expected lsu_ecl_ale_e %b, actual %b at address %h",
                     test_name, exp_ale, lsu_ecl_ale_e, addr);
         end
         if (lsu_ecl_ale_e === 1'b1 && data_req !== 1'b0) begin
            errors++;
            $display("%s: data_req raised for the misaligned access at %h", test_name, addr);
         end
         if (!exp_ale && data_wr !== exp_wr) begin
            errors++;
            $display("Mismatch in %s: expected data_wr %b, actual %b at address %h",
                     test_name, exp_wr, data_wr, addr);
         end
         sb.push_back(expected_result(op, addr, shadow[addr[7:2]], rd, wen));
         if (!exp_ale) begin
            write_shadow(op, addr, wdata);
         end
      end
   endtask

   task automatic start_test(input string name, input int grant, input int resp);
      test_name = name;
      grant_pct = grant;
      resp_pct  = resp;
   endtask

   task automatic finish_test();
      int waited;
      waited = 0;
      @(negedge clk);
      valid_e = 1'b0;
      #1;
      while (sb.size() != 0 && waited < 5000) begin
         waited++;
         @(negedge clk);
         #1;
      end
      if (sb.size() != 0) begin
         abort_run($sformatf("%s: operations never completed", test_name));
      end else begin
         $display("test %s finished with %0d errors", test_name, errors - test_errors);
         test_errors = errors;
      end
   endtask

   initial begin
      lsu_addr_t a;
      lsu_op_e   op;
      void'($urandom(32'hd2589e01));
      rst         = 1'b1;
      valid_e     = 1'b0;
      exec_req    = '0;
      checks      = 0;
      errors      = 0;
      test_errors = 0;
      for (int i = 0; i < 64; i++) begin
         shadow[i] = fill_word(i);
      end

      start_test("reset", 70, 60);
      for (int i = 0; i < 7; i++) begin
         @(posedge clk);
         @(negedge clk);
         if (data_req !== 1'b0 || lsu_addr_finish !== 1'b0 || lsu_finish_m !== 1'b0) begin
            errors++;
            $display("Mismatch in %s: expected req/addr_finish/finish_m 000, actual %b%b%b",
                     test_name, data_req, lsu_addr_finish, lsu_finish_m);
         end
         if (i == 4) begin
            rst = 1'b0;
         end
      end
      finish_test();

      start_test("aligned_loads", 70, 60);
      for (int w = 3; w < 64; w += 37) begin
         for (int lane = 0; lane < 4; lane++) begin
            a = lsu_addr_t'(w * 4 + lane);
            issue_op(op_ld_b, a, '0, 5'(lane + 1), 1'b1);
            issue_op(op_ld_bu, a, '0, 5'(lane + 9), 1'b1);
            if (lane % 2 == 0) begin
               issue_op(op_ld_h, a, '0, 5'(lane + 17), 1'b1);
               issue_op(op_ld_hu, a, '0, 5'(lane + 21), 1'b1);
            end
            if (lane == 0) begin
               issue_op(op_ld_w, a, '0, 5'd31, 1'b1);
            end
         end
      end
      finish_test();

      start_test("stores", 70, 60);
      for (int lane = 0; lane < 4; lane++) begin
         issue_op(op_st_b, lsu_addr_t'(40 + lane), $urandom(), 5'd0, 1'b0);
         issue_op(op_ld_w, lsu_addr_t'(40), '0, 5'd7, 1'b1);
         if (lane % 2 == 0) begin
            issue_op(op_st_h, lsu_addr_t'(44 + lane), $urandom(), 5'd0, 1'b0);
            issue_op(op_ld_w, lsu_addr_t'(44), '0, 5'd8, 1'b1);
         end
      end
      issue_op(op_st_w, lsu_addr_t'(48), $urandom(), 5'd0, 1'b0);
      issue_op(op_ld_w, lsu_addr_t'(48), '0, 5'd9, 1'b1);
      finish_test();

      start_test("misaligned", 70, 60);
      issue_op(op_ld_w, lsu_addr_t'(80), '0, 5'd2, 1'b1);
      issue_op(op_ld_h, lsu_addr_t'(81), '0, 5'd3, 1'b1);
      issue_op(op_ld_w, lsu_addr_t'(82), '0, 5'd4, 1'b1);
      issue_op(op_st_h, lsu_addr_t'(83), $urandom(), 5'd0, 1'b0);
      issue_op(op_st_w, lsu_addr_t'(85), $urandom(), 5'd6, 1'b0);
      issue_op(op_ld_hu, lsu_addr_t'(86), '0, 5'd5, 1'b1);
      issue_op(op_ld_w, lsu_addr_t'(84), '0, 5'd10, 1'b1);
      finish_test();

      start_test("random_stream", 30, 15);
      for (int n = 0; n < 200; n++) begin
         op = lsu_op_e'($urandom_range(7, 0));
         a  = lsu_addr_t'($urandom_range(255, 0));
         if ($urandom_range(1, 0) == 1) begin
            a[1:0] = 2'b00;
         end
         issue_op(op, a, $urandom(), 5'($urandom()), 1'($urandom()));
      end
      finish_test();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* filelist.f */
+incdir+include
src/lsu_op_pkg.sv
src/lsu_mem_pkg.sv
src/lsu_issue.sv
src/lsu_pending_queue.sv
src/lsu_result_align.sv
src/lsu_top.sv
sim/lsu_props.sv
sim/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module lsu_tb -f filelist.f -o lsu_sim

./obj_dir/lsu_sim 2>&1 | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed"
exit 1
